//--- logic/memOpPkg.sv
/*
 * Memory micro-op types for the tag-access stage.
 * Covers op payloads, load/store unit results, execution states
 * and the replay queue record. Imported by the lane resolvers.
 */
`default_nettype none

package memOpPkg;

    localparam int addrWidth          = 32;
    localparam int dataWidth          = 32;
    localparam int lineByteBits       = 4;
    localparam int indexSubsetBits    = 4;
    localparam int activeListPtrWidth = 6;
    localparam int mshrNum            = 4;
    localparam int mshrIdWidth        = $clog2(mshrNum);

    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } accessSize_t;

    typedef enum logic [3:0] {
        notFinished,
        success,
        refetchThis,
        refetchNext,
        faultLoadViolation,
        faultLoadMisaligned,
        faultStoreViolation,
        faultStoreMisaligned
    } execState_t;

    // One op as held in a lane register
    typedef struct packed {
        logic [activeListPtrWidth-1:0] activeListPtr;
        logic [addrWidth-1:0]          pc;
        logic [addrWidth-1:0]          addr;
        accessSize_t                   accessSize;
        logic                          mapIllegal;
        logic [dataWidth-1:0]          dataIn;
        logic                          regValid;
        logic                          hasAllocatedMshr;
        logic [mshrIdWidth-1:0]        mshrId;
    } memOp_t;

    // Load lane status returned by the LSU in the same cycle
    typedef struct packed {
        logic                   storeLoadForwarded;
        logic                   forwardMiss;
        logic                   dcReadHit;
        logic                   mshrReadHit;
        logic                   mshrAddrHit;
        logic                   allocatedMshr;
        logic [mshrIdWidth-1:0] allocatedMshrId;
        logic [mshrIdWidth-1:0] addrHitMshrId;
    } lsuLoadResult_t;

    typedef struct packed {
        logic                 execute;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        accessSize_t          accessSize;
    } lsuAccess_t;

    typedef struct packed {
        logic                          record;
        logic [activeListPtrWidth-1:0] activeListPtr;
        logic [addrWidth-1:0]          pc;
        logic                          hasAllocatedMshr;
        logic [mshrIdWidth-1:0]        mshrId;
        logic                          addrHit;
        logic [indexSubsetBits-1:0]    addrSubset;
    } replayRecord_t;

    typedef struct packed {
        logic                          valid;
        logic                          regValid;
        execState_t                    execState;
        logic [activeListPtrWidth-1:0] activeListPtr;
        logic [addrWidth-1:0]          pc;
        logic [addrWidth-1:0]          addr;
        logic                          hasAllocatedMshr;
        logic [mshrIdWidth-1:0]        mshrId;
    } stageOut_t;

    // Natural alignment check per access size
    function automatic logic isMisaligned(input logic [addrWidth-1:0] addr,
                                          input accessSize_t size);
        case (size)
            sizeHalf: return addr[0];
            sizeWord: return |addr[1:0];
            default:  return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- logic/recoveryPkg.sv
/*
 * Pipeline control and recovery flush types.
 * inFlushRange tells whether an active-list pointer is being squashed.
 */
`default_nettype none

package recoveryPkg;

    typedef struct packed {
        logic                                     toRecoveryPhase;
        logic                                     flushAll;
        logic [memOpPkg::activeListPtrWidth-1:0] headPtr;
        logic [memOpPkg::activeListPtrWidth-1:0] tailPtr;
    } flushCtrl_t;

    typedef struct packed {
        logic stall;
        logic clear;
    } stageCtrl_t;

    // Half-open range [head, tail), wrapping when head is past tail
    function automatic logic inFlushRange(
        input flushCtrl_t                              f,
        input logic [memOpPkg::activeListPtrWidth-1:0] ptr
    );
        logic inRange;
        if (f.headPtr < f.tailPtr) begin
            inRange = (ptr >= f.headPtr) && (ptr < f.tailPtr);
        end else if (f.headPtr > f.tailPtr) begin
            inRange = (ptr >= f.headPtr) || (ptr < f.tailPtr);
        end else begin
            // Empty range
            inRange = 1'b0;
        end
        return f.toRecoveryPhase && (f.flushAll || inRange);
    endfunction

endpackage

`default_nettype wire

//--- logic/stageReg.sv
/*
 * Lane pipeline register with a valid bit, generic over the payload.
 * Holds under stall; live marks an op that may act this cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payload_t = logic
) (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire recoveryPkg::stageCtrl_t ctrl,
    input  wire logic                    inValid,
    input  wire payload_t                in,
    output payload_t                     op,
    output logic                         live
);

    logic validQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (!ctrl.stall) begin
            validQ <= inValid;
        end
    end

    // Payload only matters while validQ is set
    always_ff @(posedge clk) begin
        if (!ctrl.stall) begin
            op <= in;
        end
    end

    assign live = validQ && !ctrl.stall && !ctrl.clear;

    // An unknown stall or valid would corrupt the held op
    ctrlKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown({ctrl, inValid}));

endmodule

`default_nettype wire

//--- logic/loadResolve.sv
/*
 * Load lane resolution in the tag-access stage.
 * Picks the result source, sets the execution state and faults,
 * strobes the LSU and builds the replay record for missed loads.
 */
`timescale 1ns/1ps
`default_nettype none

module loadResolve (
    input  wire memOpPkg::memOp_t          op,
    input  wire logic                      live,
    input  wire recoveryPkg::flushCtrl_t   flush,
    input  wire memOpPkg::lsuLoadResult_t  lsu,
    output memOpPkg::stageOut_t            out,
    output memOpPkg::lsuAccess_t           access,
    output logic                           dcReadCancel,
    output memOpPkg::replayRecord_t        replay
);
    import memOpPkg::*;
    import recoveryPkg::*;

    logic                   updated;
    logic                   hasMshr;
    logic [mshrIdWidth-1:0] mshrId;
    logic                   hit;
    logic                   regValid;
    execState_t             state;

    always_comb begin
        updated = live && !inFlushRange(flush, op.activeListPtr);

        // MSHR ownership; an earlier allocation wins over this cycle's
        if (op.hasAllocatedMshr) begin
            hasMshr = 1'b1;
            mshrId  = op.mshrId;
        end else begin
            hasMshr = lsu.allocatedMshr;
            if (lsu.allocatedMshr) begin
                mshrId = lsu.allocatedMshrId;
            end else if (lsu.mshrAddrHit) begin
                mshrId = lsu.addrHitMshrId;
            end else begin
                mshrId = op.mshrId;
            end
        end

        // Data source priority
        if (lsu.storeLoadForwarded) begin
            hit = !lsu.forwardMiss;
        end else if (hasMshr) begin
            hit = lsu.mshrReadHit;
        end else if (lsu.mshrReadHit) begin
            hit = 1'b1;
        end else begin
            hit = lsu.dcReadHit;
        end
        regValid = hit && op.regValid;

        if (!updated || !regValid) begin
            state = notFinished;
        end else begin
            state = success;
        end

        // Faults only replace a clean finish
        if (state == success) begin
            if (op.mapIllegal) begin
                state = faultLoadViolation;
            end else if (isMisaligned(op.addr, op.accessSize)) begin
                state = faultLoadMisaligned;
            end
        end

        if (live) begin
            forwardMissNeedsForward: assert (!lsu.forwardMiss || lsu.storeLoadForwarded)
                else $error("forwardMiss without storeLoadForwarded");
        end
    end

    // Forwarded data makes the cache read pointless
    assign dcReadCancel = updated && lsu.storeLoadForwarded;

    assign access.execute    = updated;
    assign access.addr       = op.addr;
    assign access.data       = op.dataIn;
    assign access.accessSize = op.accessSize;

    assign replay.record           = updated && !regValid;
    assign replay.activeListPtr    = op.activeListPtr;
    assign replay.pc               = op.pc;
    assign replay.hasAllocatedMshr = hasMshr;
    assign replay.mshrId           = mshrId;
    assign replay.addrHit          = lsu.mshrAddrHit;
    assign replay.addrSubset       = op.addr[lineByteBits +: indexSubsetBits];

    assign out.valid            = updated;
    assign out.regValid         = regValid;
    assign out.execState        = state;
    assign out.activeListPtr    = op.activeListPtr;
    assign out.pc               = op.pc;
    assign out.addr             = op.addr;
    assign out.hasAllocatedMshr = hasMshr;
    assign out.mshrId           = mshrId;

endmodule

`default_nettype wire

//--- logic/storeResolve.sv
/*
 * Store lane resolution in the tag-access stage.
 * Flags memory-order violations, checks faults and strobes the LSU.
 */
`timescale 1ns/1ps
`default_nettype none

module storeResolve (
    input  wire memOpPkg::memOp_t        op,
    input  wire logic                    live,
    input  wire recoveryPkg::flushCtrl_t flush,
    input  wire logic                    conflict,
    output memOpPkg::stageOut_t          out,
    output memOpPkg::lsuAccess_t         access,
    output logic                         orderViolation,
    output memOpPkg::replayRecord_t      replay
);
    import memOpPkg::*;
    import recoveryPkg::*;

    logic       updated;
    execState_t state;

    always_comb begin
        updated        = live && !inFlushRange(flush, op.activeListPtr);
        orderViolation = 1'b0;

        if (!updated || !op.regValid) begin
            state = notFinished;
        end else if (conflict) begin
            // Store itself is fine, younger loads must refetch
            state          = refetchNext;
            orderViolation = 1'b1;
        end else begin
            state = success;
        end

        if (state inside {success, refetchNext}) begin
            if (op.mapIllegal) begin
                state = faultStoreViolation;
            end else if (isMisaligned(op.addr, op.accessSize)) begin
                state = faultStoreMisaligned;
            end
        end
    end

    assign access = '{execute: updated, addr: op.addr, data: op.dataIn,
                      accessSize: op.accessSize};

    // Stores never own an MSHR
    assign replay = '{record: updated && !op.regValid, activeListPtr: op.activeListPtr,
                      pc: op.pc, hasAllocatedMshr: 1'b0, mshrId: '0, addrHit: 1'b0,
                      addrSubset: op.addr[lineByteBits +: indexSubsetBits]};

    assign out = '{valid: updated, regValid: op.regValid, execState: state,
                   activeListPtr: op.activeListPtr, pc: op.pc, addr: op.addr,
                   hasAllocatedMshr: 1'b0, mshrId: '0};

endmodule

`default_nettype wire

//--- logic/memTagAccessStage.sv
/*
 * Tag-access stage of the memory pipeline, one load and one store lane.
 * Each lane registers its op for one cycle, then resolves it
 * combinationally against LSU status and the recovery flush range.
 */
`timescale 1ns/1ps
`default_nettype none

module memTagAccessStage (
    input  wire logic                     clk,
    input  wire logic                     rstN,
    input  wire recoveryPkg::stageCtrl_t  ctrl,
    input  wire recoveryPkg::flushCtrl_t  flush,
    input  wire memOpPkg::memOp_t         ldIn,
    input  wire logic                     ldInValid,
    input  wire memOpPkg::memOp_t         stIn,
    input  wire logic                     stInValid,
    input  wire memOpPkg::lsuLoadResult_t ldLsu,
    input  wire logic                     stConflict,
    output memOpPkg::stageOut_t           ldOut,
    output memOpPkg::stageOut_t           stOut,
    output memOpPkg::lsuAccess_t          ldAccess,
    output memOpPkg::lsuAccess_t          stAccess,
    output logic                          dcReadCancel,
    output logic                          orderViolation,
    output memOpPkg::replayRecord_t       ldReplay,
    output memOpPkg::replayRecord_t       stReplay
);
    import memOpPkg::*;

    memOp_t ldOp;
    memOp_t stOp;
    logic   ldLive;
    logic   stLive;

    // Load lane
    stageReg #(.payload_t(memOp_t)) ldReg (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .inValid (ldInValid),
        .in      (ldIn),
        .op      (ldOp),
        .live    (ldLive)
    );

    loadResolve loadResolve_inst (
        .op           (ldOp),
        .live         (ldLive),
        .flush        (flush),
        .lsu          (ldLsu),
        .out          (ldOut),
        .access       (ldAccess),
        .dcReadCancel (dcReadCancel),
        .replay       (ldReplay)
    );

    // Store lane
    stageReg #(.payload_t(memOp_t)) stReg (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .inValid (stInValid),
        .in      (stIn),
        .op      (stOp),
        .live    (stLive)
    );

    storeResolve storeResolve_inst (
        .op             (stOp),
        .live           (stLive),
        .flush          (flush),
        .conflict       (stConflict),
        .out            (stOut),
        .access         (stAccess),
        .orderViolation (orderViolation),
        .replay         (stReplay)
    );

endmodule

`default_nettype wire

//--- tb/tbMemTagAccess.sv
/*
 * Self-checking testbench for the memory tag-access stage.
 * Drives random load and store ops, LSU status, stall, clear and flush ranges,
 * and compares every output each cycle against a reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module tbMemTagAccess;
    import memOpPkg::*;
    import recoveryPkg::*;

    localparam int resetCycles = 5;
    localparam int testCycles  = 48;
    localparam int watchdogNs  = (resetCycles + 2 + 4 * (testCycles + 1) + 40) * 8;

    logic           clk = 1'b0;
    logic           rstN;
    stageCtrl_t     ctrl;
    flushCtrl_t     flush;
    memOp_t         ldIn;
    logic           ldInValid;
    memOp_t         stIn;
    logic           stInValid;
    lsuLoadResult_t ldLsu;
    logic           stConflict;
    stageOut_t      ldOut;
    stageOut_t      stOut;
    lsuAccess_t     ldAccess;
    lsuAccess_t     stAccess;
    logic           dcReadCancel;
    logic           orderViolation;
    replayRecord_t  ldReplay;
    replayRecord_t  stReplay;

    // Reference copy of the lane registers
    memOp_t        modelLdOp;
    memOp_t        modelStOp;
    logic          modelLdValid;
    logic          modelStValid;
    stageOut_t     expLdOut;
    stageOut_t     expStOut;
    lsuAccess_t    expLdAccess;
    lsuAccess_t    expStAccess;
    replayRecord_t expLdReplay;
    replayRecord_t expStReplay;
    logic          expCancel;
    logic          expViolation;

    logic [31:0] lfsrState = 32'h4a11;
    logic        checkEn = 1'b0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          testCount = 0;

    memTagAccessStage memTagAccessStage_inst (
        .clk            (clk),
        .rstN           (rstN),
        .ctrl           (ctrl),
        .flush          (flush),
        .ldIn           (ldIn),
        .ldInValid      (ldInValid),
        .stIn           (stIn),
        .stInValid      (stInValid),
        .ldLsu          (ldLsu),
        .stConflict     (stConflict),
        .ldOut          (ldOut),
        .stOut          (stOut),
        .ldAccess       (ldAccess),
        .stAccess       (stAccess),
        .dcReadCancel   (dcReadCancel),
        .orderViolation (orderViolation),
        .ldReplay       (ldReplay),
        .stReplay       (stReplay)
    );

    always #4 clk = ~clk;

    // Galois LFSR, right shift, polynomial x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic memOp_t randomOp(input int illegalBits);
        memOp_t     op;
        logic [1:0] size;
        size = 2'(randBits(2));
        if (size == 2'd3) begin
            size = 2'd2;
        end
        op.activeListPtr    = activeListPtrWidth'(randBits(activeListPtrWidth));
        op.pc               = randBits(addrWidth);
        op.addr             = randBits(addrWidth);
        op.accessSize       = accessSize_t'(size);
        op.mapIllegal       = (randBits(illegalBits) == 0);
        op.dataIn           = randBits(dataWidth);
        op.regValid         = (randBits(3) != 0);
        op.hasAllocatedMshr = 1'(randBits(1));
        op.mshrId           = mshrIdWidth'(randBits(mshrIdWidth));
        return op;
    endfunction

    function automatic lsuLoadResult_t randomLsu();
        lsuLoadResult_t l;
        l.storeLoadForwarded = (randBits(2) == 0);
        // A miss is only reported for a forwarded load
        l.forwardMiss        = l.storeLoadForwarded && 1'(randBits(1));
        l.dcReadHit          = 1'(randBits(1));
        l.mshrReadHit        = 1'(randBits(1));
        l.mshrAddrHit        = 1'(randBits(1));
        l.allocatedMshr      = 1'(randBits(1));
        l.allocatedMshrId    = mshrIdWidth'(randBits(mshrIdWidth));
        l.addrHitMshrId      = mshrIdWidth'(randBits(mshrIdWidth));
        return l;
    endfunction

    function automatic flushCtrl_t randomFlush();
        flushCtrl_t f;
        f.toRecoveryPhase = (randBits(3) != 0);
        f.flushAll        = (randBits(3) == 0);
        f.headPtr         = activeListPtrWidth'(randBits(activeListPtrWidth));
        f.tailPtr         = activeListPtrWidth'(randBits(activeListPtrWidth));
        return f;
    endfunction

    function automatic logic flushHits(input flushCtrl_t f,
                                       input logic [activeListPtrWidth-1:0] ptr);
        if (!f.toRecoveryPhase) begin
            return 1'b0;
        end
        if (f.flushAll) begin
            return 1'b1;
        end
        if (f.headPtr == f.tailPtr) begin
            return 1'b0;
        end
        if (f.headPtr < f.tailPtr) begin
            return (ptr >= f.headPtr) && (ptr < f.tailPtr);
        end
        return (ptr >= f.headPtr) || (ptr < f.tailPtr);
    endfunction

    function automatic logic misalignedRef(input logic [addrWidth-1:0] addr,
                                           input accessSize_t size);
        if (size == sizeHalf) begin
            return addr[0];
        end
        if (size == sizeWord) begin
            return addr[1] || addr[0];
        end
        return 1'b0;
    endfunction

    function automatic void refLoad(input memOp_t op, input logic live, input flushCtrl_t f,
                                    input lsuLoadResult_t lsu, output stageOut_t o,
                                    output lsuAccess_t a, output replayRecord_t r,
                                    output logic cancel);
        logic                   upd;
        logic                   own;
        logic                   hit;
        logic                   rv;
        logic [mshrIdWidth-1:0] id;
        upd = live && !flushHits(f, op.activeListPtr);
        own = op.hasAllocatedMshr || lsu.allocatedMshr;
        if (op.hasAllocatedMshr) begin
            id = op.mshrId;
        end else if (lsu.allocatedMshr) begin
            id = lsu.allocatedMshrId;
        end else if (lsu.mshrAddrHit) begin
            id = lsu.addrHitMshrId;
        end else begin
            id = op.mshrId;
        end
        if (lsu.storeLoadForwarded) begin
            hit = !lsu.forwardMiss;
        end else if (own) begin
            hit = lsu.mshrReadHit;
        end else begin
            hit = lsu.mshrReadHit || lsu.dcReadHit;
        end
        rv = hit && op.regValid;
        o = '0;
        o.valid     = upd;
        o.regValid  = rv;
        o.execState = notFinished;
        if (upd && rv) begin
            if (op.mapIllegal) begin
                o.execState = faultLoadViolation;
            end else if (misalignedRef(op.addr, op.accessSize)) begin
                o.execState = faultLoadMisaligned;
            end else begin
                o.execState = success;
            end
        end
        o.activeListPtr    = op.activeListPtr;
        o.pc               = op.pc;
        o.addr             = op.addr;
        o.hasAllocatedMshr = own;
        o.mshrId           = id;
        a = '{execute: upd, addr: op.addr, data: op.dataIn, accessSize: op.accessSize};
        r = '{record: upd && !rv, activeListPtr: op.activeListPtr, pc: op.pc,
              hasAllocatedMshr: own, mshrId: id, addrHit: lsu.mshrAddrHit,
              addrSubset: op.addr[lineByteBits +: indexSubsetBits]};
        cancel = upd && lsu.storeLoadForwarded;
    endfunction

    function automatic void refStore(input memOp_t op, input logic live, input flushCtrl_t f,
                                     input logic conflict, output stageOut_t o,
                                     output lsuAccess_t a, output replayRecord_t r,
                                     output logic viol);
        logic       upd;
        execState_t state;
        upd   = live && !flushHits(f, op.activeListPtr);
        viol  = 1'b0;
        state = notFinished;
        if (upd && op.regValid) begin
            viol  = conflict;
            state = conflict ? refetchNext : success;
            if (op.mapIllegal) begin
                state = faultStoreViolation;
            end else if (misalignedRef(op.addr, op.accessSize)) begin
                state = faultStoreMisaligned;
            end
        end
        o = '0;
        o.valid         = upd;
        o.regValid      = op.regValid;
        o.execState     = state;
        o.activeListPtr = op.activeListPtr;
        o.pc            = op.pc;
        o.addr          = op.addr;
        a = '{execute: upd, addr: op.addr, data: op.dataIn, accessSize: op.accessSize};
        r = '0;
        r.record        = upd && !op.regValid;
        r.activeListPtr = op.activeListPtr;
        r.pc            = op.pc;
        r.addrSubset    = op.addr[lineByteBits +: indexSubsetBits];
    endfunction

    task automatic checkOut(input string name, input stageOut_t got, input stageOut_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkAccess(input string name, input lsuAccess_t got, input lsuAccess_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkReplay(input string name, input replayRecord_t got,
                               input replayRecord_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // Mirrors the lane registers, holding under stall
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            modelLdValid <= 1'b0;
            modelStValid <= 1'b0;
        end else if (!ctrl.stall) begin
            modelLdValid <= ldInValid;
            modelStValid <= stInValid;
        end
    end

    always @(posedge clk) begin
        if (!ctrl.stall) begin
            modelLdOp <= ldIn;
            modelStOp <= stIn;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (checkEn) begin
            refLoad(modelLdOp, modelLdValid && !ctrl.stall && !ctrl.clear, flush, ldLsu,
                    expLdOut, expLdAccess, expLdReplay, expCancel);
            refStore(modelStOp, modelStValid && !ctrl.stall && !ctrl.clear, flush, stConflict,
                     expStOut, expStAccess, expStReplay, expViolation);
            checkOut("ldOut", ldOut, expLdOut);
            checkAccess("ldAccess", ldAccess, expLdAccess);
            checkReplay("ldReplay", ldReplay, expLdReplay);
            checkBit("dcReadCancel", dcReadCancel, expCancel);
            checkOut("stOut", stOut, expStOut);
            checkAccess("stAccess", stAccess, expStAccess);
            checkReplay("stReplay", stReplay, expStReplay);
            checkBit("orderViolation", orderViolation, expViolation);
        end
    end

    task automatic driveCycle(input int mode);
        ldInValid  <= (mode == 2) ? (randBits(3) != 0) : (randBits(2) != 0);
        ldIn       <= randomOp(3);
        ldLsu      <= randomLsu();
        stInValid  <= (mode == 2) ? 1'b0 : ((mode == 3) || (randBits(2) != 0));
        stIn       <= randomOp((mode == 3) ? 2 : 3);
        stConflict <= 1'(randBits(1));
        if (mode == 4) begin
            ctrl <= '{stall: (randBits(2) == 0), clear: (randBits(2) == 0)};
        end else begin
            ctrl <= '0;
        end
        flush <= (mode == 5) ? randomFlush() : '0;
    endtask

    task automatic reportTest(input string name, input int chkBefore, input int errBefore);
        testCount++;
        $display("%s: %0d checks, %0d errors", name, checkCount - chkBefore,
                 errorCount - errBefore);
    endtask

    task automatic runTest(input string name, input int mode);
        int chkBefore;
        int errBefore;
        chkBefore = checkCount;
        errBefore = errorCount;
        repeat (testCycles) begin
            @(posedge clk);
            driveCycle(mode);
        end
        @(posedge clk);
        reportTest(name, chkBefore, errBefore);
    endtask

    initial begin
        #(watchdogNs);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        // Valid inputs stay high through reset, so only rstN keeps the lanes empty
        rstN       = 1'b0;
        ctrl       = '0;
        flush      = '0;
        ldIn       = '0;
        ldInValid  = 1'b1;
        stIn       = '0;
        stInValid  = 1'b1;
        ldLsu      = '0;
        stConflict = 1'b0;
        repeat (resetCycles) @(posedge clk);

        // Registered valid bits are still clear right after reset
        rstN    <= 1'b1;
        checkEn <= 1'b1;
        @(negedge clk);
        checkBit("ldOut.valid", ldOut.valid, 1'b0);
        checkBit("stOut.valid", stOut.valid, 1'b0);
        checkBit("ldAccess.execute", ldAccess.execute, 1'b0);
        checkBit("stAccess.execute", stAccess.execute, 1'b0);
        checkBit("dcReadCancel", dcReadCancel, 1'b0);
        checkBit("orderViolation", orderViolation, 1'b0);
        checkBit("ldReplay.record", ldReplay.record, 1'b0);
        checkBit("stReplay.record", stReplay.record, 1'b0);
        reportTest("reset state", 0, 0);

        runTest("random loads", 2);
        runTest("random stores", 3);
        runTest("stall and clear", 4);
        runTest("flush range", 5);

        // Lets the last registered op reach its check
        @(posedge clk);

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/memOpPkg.sv
logic/recoveryPkg.sv
logic/stageReg.sv
logic/loadResolve.sv
logic/storeResolve.sv
logic/memTagAccessStage.sv
tb/tbMemTagAccess.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tbMemTagAccess --Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
